// ==== project.f ====
src/mcu_com_pkg.sv
src/spi_slave.sv
src/mcu_fpga_com.sv
src/object_buffer.sv
src/mcu_link_top.sv
verif/mcu_link_asserts.sv
verif/tb_mcu_link.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_mcu_link
FILELIST   = project.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = test passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tb_mcu_link.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mcu_link;

    localparam int     HALF_SCK    = 4;
    // Bytes over all frames, 148 + 1 + 61 + 50
    localparam int     TOTAL_BYTES = 260;
    localparam longint WATCHDOG_NS = 2 * TOTAL_BYTES * 8 * 80 + 10_000;

    logic                     clk;
    logic                     rstn;
    logic                     sck;
    logic                     mosi;
    logic                     csn;
    logic                     miso;
    logic                     new_frame;
    logic                     mcu_ready;
    mcu_com_pkg::byte_t       num_objects;
    logic                     num_objects_dv;
    mcu_com_pkg::obj_record_t obj_out;
    logic                     object_dv;
    logic                     frame_done;
    mcu_com_pkg::obj_id_t     rd_id;
    mcu_com_pkg::obj_record_t rd_object;

    logic [15:0]              lfsr_state = 16'd7504;
    mcu_com_pkg::byte_t       frame_q[$];
    mcu_com_pkg::obj_record_t exp_q[$];
    mcu_com_pkg::byte_t       got_cnt_q[$];
    mcu_com_pkg::obj_record_t got_obj_q[$];
    int                       done_cnt = 0;
    int                       mismatch_cnt = 0;
    int                       other_cnt = 0;

    mcu_link_top #(
        .SYNC_STAGES(2)
    ) DUT (
        .clk             (clk),
        .rstn            (rstn),
        .i_sck           (sck),
        .i_mosi          (mosi),
        .i_csn           (csn),
        .o_miso          (miso),
        .i_new_frame     (new_frame),
        .o_mcu_ready     (mcu_ready),
        .o_num_objects   (num_objects),
        .o_num_objects_dv(num_objects_dv),
        .o_object        (obj_out),
        .o_object_dv     (object_dv),
        .o_frame_done    (frame_done),
        .i_rd_id         (rd_id),
        .o_rd_object     (rd_object)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("test failed");
        $finish;
    end

    // Strobe monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rstn) begin
            if (num_objects_dv) begin
                got_cnt_q.push_back(num_objects);
            end
            if (object_dv) begin
                got_obj_q.push_back(obj_out);
            end
            if (frame_done) begin
                done_cnt++;
            end
        end
    end

    function automatic logic lfsr_step();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out_bit;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_step()};
        end
        return r;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic report_mismatch(input string msg);
        mismatch_cnt++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    task automatic report_failure(input string msg);
        other_cnt++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic clear_monitor();
        got_cnt_q.delete();
        got_obj_q.delete();
        done_cnt = 0;
    endtask

    // Object k gets id first_id + 5k, values MSB first in row-major order
    task automatic build_frame(input int count, input int first_id);
        mcu_com_pkg::obj_record_t rec;
        logic [31:0]              r;
        frame_q.delete();
        exp_q.delete();
        frame_q.push_back(mcu_com_pkg::byte_t'(count));
        for (int k = 0; k < count; k++) begin
            rec.id = mcu_com_pkg::obj_id_t'((first_id + 5 * k) % 16);
            r = random_bits(4);
            rec.flags = r[3:0];
            frame_q.push_back({rec.id, rec.flags});
            for (int v = 0; v < mcu_com_pkg::MATRIX_VALUES; v++) begin
                r = random_bits(24);
                rec.matrix[v] = r[23:0];
                frame_q.push_back(r[23:16]);
                frame_q.push_back(r[15:8]);
                frame_q.push_back(r[7:0]);
            end
            exp_q.push_back(rec);
        end
    endtask

    // Mode 0, MISO taken just before each rising SCK edge
    task automatic send_byte(input mcu_com_pkg::byte_t tx, output mcu_com_pkg::byte_t rx);
        for (int i = 7; i >= 0; i--) begin
            sck = 1'b0;
            mosi = tx[i];
            wait_cycles(HALF_SCK);
            rx[i] = miso;
            sck = 1'b1;
            wait_cycles(HALF_SCK);
        end
    endtask

    task automatic send_frame(input int n_send);
        mcu_com_pkg::byte_t echo;
        mcu_com_pkg::byte_t prev;
        prev = '0;
        csn = 1'b0;
        wait_cycles(HALF_SCK);
        for (int i = 0; i < n_send; i++) begin
            send_byte(frame_q[i], echo);
            if (echo !== prev) begin
                report_mismatch($sformatf("byte %0d echo %h, expected %h", i, echo, prev));
            end
            prev = frame_q[i];
            if (i == 1 && mcu_ready !== 1'b0) begin
                report_mismatch("ready high while a frame is being sent");
            end
        end
        sck = 1'b0;
        wait_cycles(HALF_SCK);
        csn = 1'b1;
        wait_cycles(2 * HALF_SCK);
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (done_cnt == 0 && n < 200) begin
            wait_cycles(1);
            n++;
        end
        if (done_cnt == 0) begin
            report_failure("frame done never came");
        end
    endtask

    task automatic check_records(input int n);
        for (int k = 0; k < n && k < got_obj_q.size(); k++) begin
            if (got_obj_q[k] !== exp_q[k]) begin
                report_mismatch($sformatf("object %0d id %h flags %h, expected id %h flags %h",
                    k, got_obj_q[k].id, got_obj_q[k].flags, exp_q[k].id, exp_q[k].flags));
            end
        end
    endtask

    task automatic check_frame(input int count);
        if (got_cnt_q.size() != 1) begin
            report_failure($sformatf("%0d count strobes instead of one", got_cnt_q.size()));
        end else if (got_cnt_q[0] !== mcu_com_pkg::byte_t'(count)) begin
            report_mismatch($sformatf("count %0d, expected %0d", got_cnt_q[0], count));
        end
        if (got_obj_q.size() != count) begin
            report_failure($sformatf("%0d object strobes, expected %0d", got_obj_q.size(), count));
        end
        check_records(count);
        if (done_cnt != 1) begin
            report_failure($sformatf("%0d frame done strobes instead of one", done_cnt));
        end
        if (mcu_ready !== 1'b1) begin
            report_mismatch("ready low after the frame ended");
        end
    endtask

    task automatic test_ready();
        if (mcu_ready !== 1'b1) begin
            report_mismatch("ready low while idle with new frame high");
        end
        new_frame = 1'b0;
        wait_cycles(1);
        if (mcu_ready !== 1'b0) begin
            report_mismatch("ready high with new frame low");
        end
        new_frame = 1'b1;
        wait_cycles(1);
        if (mcu_ready !== 1'b1) begin
            report_mismatch("ready did not return with new frame");
        end
    endtask

    task automatic test_frame();
        build_frame(3, 3);
        clear_monitor();
        send_frame(frame_q.size());
        wait_done();
        check_frame(3);
    endtask

    task automatic test_readback();
        for (int k = 0; k < exp_q.size(); k++) begin
            rd_id = exp_q[k].id;
            wait_cycles(1);
            if (rd_object !== exp_q[k]) begin
                report_mismatch($sformatf("buffer readback of id %h", exp_q[k].id));
            end
        end
        // Id 5 is never written
        rd_id = 4'd5;
        wait_cycles(1);
        if (rd_object !== '0) begin
            report_mismatch("unwritten id 5 reads back nonzero");
        end
    endtask

    task automatic test_empty();
        build_frame(0, 0);
        clear_monitor();
        send_frame(1);
        wait_done();
        check_frame(0);
    endtask

    task automatic test_abort();
        build_frame(2, 10);
        clear_monitor();
        // Cut inside the second object's matrix
        send_frame(1 + 49 + 1 + 10);
        wait_cycles(50);
        if (got_obj_q.size() != 1) begin
            report_failure($sformatf("%0d object strobes in aborted frame", got_obj_q.size()));
        end
        check_records(1);
        if (done_cnt != 0) begin
            report_failure("frame done after an aborted frame");
        end
        build_frame(1, 6);
        clear_monitor();
        send_frame(frame_q.size());
        wait_done();
        check_frame(1);
    endtask

    initial begin
        rstn = 1'b0;
        sck = 1'b0;
        mosi = 1'b0;
        csn = 1'b1;
        new_frame = 1'b1;
        rd_id = '0;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
        wait_cycles(2);
        test_ready();
        test_frame();
        test_readback();
        test_empty();
        test_abort();
        $display("errors: %0d mismatches, %0d other, %0d assertion failures",
            mismatch_cnt, other_cnt, DUT.u_asserts.fail_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0 && DUT.u_asserts.fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/mcu_link_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcu_link_asserts (
    input logic clk,
    input logic rstn,
    input logic i_new_frame,
    input logic i_mcu_ready,
    input logic i_num_objects_dv,
    input logic i_object_dv,
    input logic i_frame_done
);

    int   fail_cnt = 0;
    logic frame_closed;

    // Set by frame done, cleared by the next count strobe
    always_ff @(posedge clk) begin
        if (!rstn) begin
            frame_closed <= 1'b0;
        end else if (i_frame_done) begin
            frame_closed <= 1'b1;
        end else if (i_num_objects_dv) begin
            frame_closed <= 1'b0;
        end
    end

    strobes_apart: assert property (@(posedge clk) disable iff (!rstn)
        !(i_object_dv && i_frame_done))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("object strobe and frame done in the same cycle");
        end

    no_object_after_done: assert property (@(posedge clk) disable iff (!rstn)
        !(frame_closed && i_object_dv))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("object strobe after frame done without a new count strobe");
        end

    ready_needs_new_frame: assert property (@(posedge clk) disable iff (!rstn)
        i_mcu_ready |-> i_new_frame)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("ready high while new frame input is low");
        end

endmodule

bind mcu_link_top mcu_link_asserts u_asserts (
    .clk             (clk),
    .rstn            (rstn),
    .i_new_frame     (i_new_frame),
    .i_mcu_ready     (o_mcu_ready),
    .i_num_objects_dv(o_num_objects_dv),
    .i_object_dv     (o_object_dv),
    .i_frame_done    (o_frame_done)
);

`default_nettype wire

// ==== src/mcu_link_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcu_link_top #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     i_sck,
    input  logic                     i_mosi,
    input  logic                     i_csn,
    output logic                     o_miso,
    input  logic                     i_new_frame,
    output logic                     o_mcu_ready,
    output mcu_com_pkg::byte_t       o_num_objects,
    output logic                     o_num_objects_dv,
    output mcu_com_pkg::obj_record_t o_object,
    output logic                     o_object_dv,
    output logic                     o_frame_done,
    input  mcu_com_pkg::obj_id_t     i_rd_id,
    output mcu_com_pkg::obj_record_t o_rd_object
);

    mcu_com_pkg::byte_t rx_byte;
    logic               rx_dv;
    logic               csn_sync;

    spi_slave #(
        .SYNC_STAGES(SYNC_STAGES)
    ) u_spi_slave (
        .clk       (clk),
        .rstn      (rstn),
        .i_sck     (i_sck),
        .i_mosi    (i_mosi),
        .i_csn     (i_csn),
        .o_miso    (o_miso),
        .o_rx_byte (rx_byte),
        .o_rx_dv   (rx_dv),
        .o_csn_sync(csn_sync)
    );

    mcu_fpga_com u_mcu_fpga_com (
        .clk             (clk),
        .rstn            (rstn),
        .i_new_frame     (i_new_frame),
        .i_csn_sync      (csn_sync),
        .i_rx_byte       (rx_byte),
        .i_rx_dv         (rx_dv),
        .o_mcu_ready     (o_mcu_ready),
        .o_num_objects   (o_num_objects),
        .o_num_objects_dv(o_num_objects_dv),
        .o_object        (o_object),
        .o_object_dv     (o_object_dv),
        .o_frame_done    (o_frame_done)
    );

    // Buffer is written straight from the parser's object strobe
    object_buffer u_object_buffer (
        .clk        (clk),
        .rstn       (rstn),
        .i_wr_object(o_object),
        .i_wr_en    (o_object_dv),
        .i_rd_id    (i_rd_id),
        .o_rd_object(o_rd_object)
    );

endmodule

`default_nettype wire

// ==== src/object_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module object_buffer (
    input  logic                     clk,
    input  logic                     rstn,
    input  mcu_com_pkg::obj_record_t i_wr_object,
    input  logic                     i_wr_en,
    input  mcu_com_pkg::obj_id_t     i_rd_id,
    output mcu_com_pkg::obj_record_t o_rd_object
);

    // One entry per possible object id
    localparam int DEPTH = 2 ** $bits(mcu_com_pkg::obj_id_t);

    mcu_com_pkg::obj_record_t mem [DEPTH];

    // Renderer expects unwritten ids to read back as zero
    always_ff @(posedge clk) begin
        if (!rstn) begin
            mem <= '{default: '0};
        end else if (i_wr_en) begin
            mem[i_wr_object.id] <= i_wr_object;
        end
    end

    // Same-cycle write and read of one id returns the old record
    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_rd_object <= '0;
        end else begin
            o_rd_object <= mem[i_rd_id];
        end
    end

endmodule

`default_nettype wire

// ==== src/mcu_fpga_com.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcu_fpga_com (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     i_new_frame,
    input  logic                     i_csn_sync,
    input  mcu_com_pkg::byte_t       i_rx_byte,
    input  logic                     i_rx_dv,
    output logic                     o_mcu_ready,
    output mcu_com_pkg::byte_t       o_num_objects,
    output logic                     o_num_objects_dv,
    output mcu_com_pkg::obj_record_t o_object,
    output logic                     o_object_dv,
    output logic                     o_frame_done
);

    localparam int VAL_CNT_W  = $clog2(mcu_com_pkg::MATRIX_VALUES);
    localparam int BYTE_CNT_W = $clog2(mcu_com_pkg::MATRIX_BYTES);
    localparam int KEEP_W     = mcu_com_pkg::MATRIX_W - 8;

    localparam logic [VAL_CNT_W-1:0]  LAST_VAL  = VAL_CNT_W'(mcu_com_pkg::MATRIX_VALUES - 1);
    localparam logic [BYTE_CNT_W-1:0] LAST_BYTE = BYTE_CNT_W'(mcu_com_pkg::MATRIX_BYTES - 1);

    mcu_com_pkg::com_state_t state;
    mcu_com_pkg::com_state_t next_state;
    mcu_com_pkg::byte_t      obj_cnt;
    logic [VAL_CNT_W-1:0]    val_cnt;
    logic [BYTE_CNT_W-1:0]   byte_cnt;
    logic                    rx_ok;
    logic                    matrix_end;

    assign rx_ok      = i_rx_dv & ~i_csn_sync;
    assign matrix_end = (val_cnt == LAST_VAL) && (byte_cnt == LAST_BYTE);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= mcu_com_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Byte-waiting states drop back to IDLE when chip select goes high
    always_comb begin
        next_state = state;
        case (state)
            mcu_com_pkg::IDLE: begin
                if (!i_csn_sync) begin
                    next_state = mcu_com_pkg::NUM_OBJECTS;
                end
            end
            mcu_com_pkg::NUM_OBJECTS: begin
                if (i_csn_sync) begin
                    next_state = mcu_com_pkg::IDLE;
                end else if (i_rx_dv) begin
                    next_state = mcu_com_pkg::OBJECTS;
                end
            end
            mcu_com_pkg::OBJECTS: begin
                if (obj_cnt == o_num_objects) begin
                    next_state = mcu_com_pkg::DONE;
                end else begin
                    next_state = mcu_com_pkg::OBJECT_HDR;
                end
            end
            mcu_com_pkg::OBJECT_HDR: begin
                if (i_csn_sync) begin
                    next_state = mcu_com_pkg::IDLE;
                end else if (i_rx_dv) begin
                    next_state = mcu_com_pkg::OBJECT_MATRIX;
                end
            end
            mcu_com_pkg::OBJECT_MATRIX: begin
                if (i_csn_sync) begin
                    next_state = mcu_com_pkg::IDLE;
                end else if (i_rx_dv && matrix_end) begin
                    next_state = mcu_com_pkg::OBJECT_DONE;
                end
            end
            mcu_com_pkg::OBJECT_DONE: next_state = mcu_com_pkg::OBJECTS;
            mcu_com_pkg::DONE:        next_state = mcu_com_pkg::IDLE;
            default:                  next_state = mcu_com_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_num_objects    <= '0;
            o_num_objects_dv <= 1'b0;
            o_object_dv      <= 1'b0;
            o_frame_done     <= 1'b0;
            obj_cnt          <= '0;
            val_cnt          <= '0;
            byte_cnt         <= '0;
        end else begin
            o_num_objects_dv <= 1'b0;
            o_object_dv      <= (state == mcu_com_pkg::OBJECT_DONE);
            o_frame_done     <= (state == mcu_com_pkg::DONE);
            case (state)
                mcu_com_pkg::NUM_OBJECTS: begin
                    if (rx_ok) begin
                        o_num_objects    <= i_rx_byte;
                        o_num_objects_dv <= 1'b1;
                        obj_cnt          <= '0;
                    end
                end
                mcu_com_pkg::OBJECT_HDR: begin
                    if (rx_ok) begin
                        val_cnt  <= '0;
                        byte_cnt <= '0;
                    end
                end
                mcu_com_pkg::OBJECT_MATRIX: begin
                    if (rx_ok) begin
                        if (byte_cnt == LAST_BYTE) begin
                            byte_cnt <= '0;
                            val_cnt  <= val_cnt + 1'b1;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                mcu_com_pkg::OBJECT_DONE: obj_cnt <= obj_cnt + 8'd1;
                default: begin
                end
            endcase
        end
    end

    // Record is assembled in place, valid while o_object_dv is high
    always_ff @(posedge clk) begin
        if (rx_ok && (state == mcu_com_pkg::OBJECT_HDR)) begin
            o_object.id    <= i_rx_byte[7:4];
            o_object.flags <= i_rx_byte[3:0];
        end
        if (rx_ok && (state == mcu_com_pkg::OBJECT_MATRIX)) begin
            o_object.matrix[val_cnt] <= {o_object.matrix[val_cnt][KEEP_W-1:0], i_rx_byte};
        end
    end

    assign o_mcu_ready = i_new_frame && (state == mcu_com_pkg::IDLE);

endmodule

`default_nettype wire

// ==== src/spi_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_slave #(
    parameter int SYNC_STAGES = 2
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               i_sck,
    input  logic               i_mosi,
    input  logic               i_csn,
    output logic               o_miso,
    output mcu_com_pkg::byte_t o_rx_byte,
    output logic               o_rx_dv,
    output logic               o_csn_sync
);

    // Synchronizer chains, pin enters at bit 0 (needs at least 2 stages)
    logic [SYNC_STAGES-1:0] sck_sync;
    logic [SYNC_STAGES-1:0] mosi_sync;
    logic [SYNC_STAGES-1:0] csn_sync;
    logic                   sck_prev;
    logic                   sck_rise;
    logic                   sck_fall;
    logic                   byte_end;
    logic [2:0]             bit_cnt;
    mcu_com_pkg::byte_t     rx_shift;
    mcu_com_pkg::byte_t     rx_next;
    mcu_com_pkg::byte_t     tx_shift;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            sck_sync  <= '0;
            mosi_sync <= '0;
            csn_sync  <= '1;
            sck_prev  <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[SYNC_STAGES-2:0], i_sck};
            mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], i_mosi};
            csn_sync  <= {csn_sync[SYNC_STAGES-2:0], i_csn};
            sck_prev  <= sck_sync[SYNC_STAGES-1];
        end
    end

    assign sck_rise   = sck_sync[SYNC_STAGES-1] & ~sck_prev;
    assign sck_fall   = ~sck_sync[SYNC_STAGES-1] & sck_prev;
    assign o_csn_sync = csn_sync[SYNC_STAGES-1];
    assign rx_next    = {rx_shift[6:0], mosi_sync[SYNC_STAGES-1]};
    assign byte_end   = sck_rise && (bit_cnt == 3'd7);

    always_ff @(posedge clk) begin
        if (!rstn || o_csn_sync) begin
            bit_cnt <= '0;
            o_rx_dv <= 1'b0;
        end else begin
            o_rx_dv <= byte_end;
            if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
            end
        end
    end

    // MSB first
    always_ff @(posedge clk) begin
        if (sck_rise) begin
            rx_shift <= rx_next;
        end
        if (byte_end) begin
            o_rx_byte <= rx_next;
        end
    end

    // Echo path, the falling edge between bytes keeps bit 7 in place
    always_ff @(posedge clk) begin
        if (!rstn || o_csn_sync) begin
            tx_shift <= '0;
        end else if (byte_end) begin
            tx_shift <= rx_next;
        end else if (sck_fall && (bit_cnt != 3'd0)) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    assign o_miso = tx_shift[7];

endmodule

`default_nettype wire

// ==== src/mcu_com_pkg.sv ====
`default_nettype none

package mcu_com_pkg;

    // Matrix value format on the wire
    localparam int MATRIX_W      = 24;
    localparam int MATRIX_BYTES  = 3;
    localparam int MATRIX_VALUES = 16;

    typedef logic [7:0]          byte_t;
    typedef logic [3:0]          obj_id_t;
    typedef logic [3:0]          obj_flags_t;
    typedef logic [MATRIX_W-1:0] mat_val_t;

    // Element 0 of matrix is row 0, column 0, values in row-major order
    typedef struct packed {
        obj_id_t                       id;
        obj_flags_t                    flags;
        mat_val_t [MATRIX_VALUES-1:0]  matrix;
    } obj_record_t;

    typedef enum logic [2:0] {
        IDLE,
        NUM_OBJECTS,
        OBJECTS,
        OBJECT_HDR,
        OBJECT_MATRIX,
        OBJECT_DONE,
        DONE
    } com_state_t;

endpackage

`default_nettype wire
